//--- nr_pbch_pkg.sv
package nr_pbch_pkg;

    // candidate SSB indices and their encoding
    localparam int NUM_IBAR = 8;
    localparam int IBAR_W = 3;

    // cell identity runs from 0 to 1007
    localparam int NID_W = 10;

    // Gold sequence generator
    localparam int LFSR_N = 31;
    localparam int GOLD_SKIP = 1600;

    // PBCH DMRS tables
    localparam int DMRS_LEN = 144;
    localparam int DMRS_IDX_W = 8;

    // OFDM symbol layout
    localparam int FFT_LEN = 256;
    localparam int PILOT_SPACING = 4;

    // I sits in the low half and Q in the high half
    localparam int IQ_W = 32;

    // correlation accumulators and their magnitudes
    localparam int CORR_W = 9;
    localparam int MAG_W = 8;

    typedef struct packed {
        logic [NID_W-1:0] n_id;
        logic             valid;
    } cell_cfg_t;

    // start marks the first sample of a PBCH symbol
    typedef struct packed {
        logic [IQ_W-1:0] data;
        logic            start;
        logic            valid;
    } iq_sample_t;

    typedef struct packed {
        logic b_hi;
        logic b_lo;
    } qpsk_bits_t;

    // one pilot index seen across all ibar candidates
    typedef qpsk_bits_t [NUM_IBAR-1:0] dmrs_row_t;

    typedef struct packed {
        logic [IBAR_W-1:0] ibar;
        logic [MAG_W-1:0]  peak;
        logic              valid;
    } ibar_result_t;

endpackage

//--- step_counter.sv
`timescale 1ns/1ns

module step_counter #(
    parameter int WIDTH = 8
) (
    input  logic             clk_i,
    input  logic             reset_ni,
    input  logic             clear_i,
    input  logic             en_i,
    input  logic [WIDTH-1:0] last_val_i,
    output logic [WIDTH-1:0] count_o,
    output logic             at_last_o
);

    // clear wins over enable so a block can restart on its final step
    always_ff @(posedge clk_i) begin
        if (!reset_ni || clear_i) begin
            count_o <= '0;
        end else if (en_i) begin
            count_o <= count_o + 1'b1;
        end
    end

    // terminal flag is combinational so the caller can act in the same cycle
    assign at_last_o = (count_o == last_val_i);

endmodule

//--- gold_seq_gen.sv
`timescale 1ns/1ns

module gold_seq_gen (
    input  logic                               clk_i,
    input  logic                               reset_ni,
    input  logic                               load_i,
    input  logic                               step_i,
    input  logic [nr_pbch_pkg::NID_W-1:0]      n_id_i,
    output logic [nr_pbch_pkg::NUM_IBAR-1:0]   gold_bits_o
);

    localparam int LN = nr_pbch_pkg::LFSR_N;
    localparam int NI = nr_pbch_pkg::NUM_IBAR;
    localparam int NW = nr_pbch_pkg::NID_W;

    typedef logic [LN-1:0] lfsr_t;

    // bit j of each register holds x(n+j), so bit 0 is the current output
    lfsr_t x1_q;
    lfsr_t x2_q [NI];
    lfsr_t c_init [NI];
    lfsr_t nid_grp;

    // c_init = 2048*(ibar+1)*(floor(n_id/4)+1) + 64*(ibar+1) + n_id mod 4
    always_comb begin
        nid_grp = lfsr_t'(n_id_i[NW-1:2]) + lfsr_t'(1);
        for (int i = 0; i < NI; i++) begin
            c_init[i] = ((lfsr_t'(i + 1) * nid_grp) << 11)
                      + (lfsr_t'(i + 1) << 6)
                      + lfsr_t'(n_id_i[1:0]);
        end
    end

    // x1 uses taps 3 and 0, each x2 uses taps 3, 2, 1 and 0
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            x1_q <= '0;
            for (int i = 0; i < NI; i++) begin
                x2_q[i] <= '0;
            end
        end else if (load_i) begin
            x1_q <= lfsr_t'(1);
            for (int i = 0; i < NI; i++) begin
                x2_q[i] <= c_init[i];
            end
        end else if (step_i) begin
            x1_q <= {x1_q[3] ^ x1_q[0], x1_q[LN-1:1]};
            for (int i = 0; i < NI; i++) begin
                x2_q[i] <= {^x2_q[i][3:0], x2_q[i][LN-1:1]};
            end
        end
    end

    // registered output gives the memory write port a clean start
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NI; i++) begin
            gold_bits_o[i] <= x1_q[0] ^ x2_q[i][0];
        end
    end

endmodule

//--- dmrs_seq_ctrl.sv
`timescale 1ns/1ns

module dmrs_seq_ctrl #(
    parameter int SKIP_LEN = nr_pbch_pkg::GOLD_SKIP
) (
    input  logic                                clk_i,
    input  logic                                reset_ni,
    input  nr_pbch_pkg::cell_cfg_t              cell_cfg_i,
    output logic                                gen_load_o,
    output logic                                gen_step_o,
    output logic                                wr_en_o,
    output logic [nr_pbch_pkg::DMRS_IDX_W-1:0]  wr_idx_o,
    output logic                                wr_lo_o,
    output logic                                dmrs_ready_o
);

    localparam int SKIP_CNT_W = 11;
    localparam int BIT_CNT_W = 9;
    localparam int STORE_LEN = 2 * nr_pbch_pkg::DMRS_LEN;
    localparam int IDX_W = nr_pbch_pkg::DMRS_IDX_W;

    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_SKIP, S_STORE} state_t;

    state_t               state_q;
    logic                 restart;
    logic                 skip_last;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic                 bit_last;
    logic                 wr_last_q;
    logic                 wr_done_q;

    assign restart = cell_cfg_i.valid;

    step_counter #(.WIDTH(SKIP_CNT_W)) i_skip_cnt (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .clear_i    (state_q != S_SKIP),
        .en_i       (state_q == S_SKIP),
        .last_val_i (SKIP_CNT_W'(SKIP_LEN - 1)),
        .count_o    (),
        .at_last_o  (skip_last)
    );

    // even counts feed b_hi, odd counts feed b_lo of the same pilot
    step_counter #(.WIDTH(BIT_CNT_W)) i_bit_cnt (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .clear_i    (state_q != S_STORE),
        .en_i       (state_q == S_STORE),
        .last_val_i (BIT_CNT_W'(STORE_LEN - 1)),
        .count_o    (bit_cnt),
        .at_last_o  (bit_last)
    );

    // a new cell identity restarts generation from any state
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= S_IDLE;
        end else if (restart) begin
            state_q <= S_LOAD;
        end else begin
            case (state_q)
                S_LOAD:  state_q <= S_SKIP;
                S_SKIP:  state_q <= skip_last ? S_STORE : S_SKIP;
                S_STORE: state_q <= bit_last ? S_IDLE : S_STORE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign gen_load_o = (state_q == S_LOAD);
    assign gen_step_o = (state_q == S_SKIP) || (state_q == S_STORE);

    // write command lines up with the registered Gold bits
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_en_o      <= 1'b0;
            wr_last_q    <= 1'b0;
            wr_done_q    <= 1'b0;
            dmrs_ready_o <= 1'b0;
        end else begin
            wr_en_o   <= (state_q == S_STORE) && !restart;
            wr_last_q <= bit_last;
            wr_done_q <= wr_en_o && wr_last_q && !restart;
            // ready follows the final write so the whole table is readable
            if (restart) begin
                dmrs_ready_o <= 1'b0;
            end else if (wr_done_q) begin
                dmrs_ready_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        wr_idx_o <= IDX_W'(bit_cnt >> 1);
        wr_lo_o  <= bit_cnt[0];
    end

endmodule

//--- dmrs_store.sv
`timescale 1ns/1ns

module dmrs_store (
    input  logic                                clk_i,
    input  logic                                wr_en_i,
    input  logic [nr_pbch_pkg::DMRS_IDX_W-1:0]  wr_idx_i,
    input  logic                                wr_lo_i,
    input  logic [nr_pbch_pkg::NUM_IBAR-1:0]    wr_bits_i,
    input  logic [nr_pbch_pkg::DMRS_IDX_W-1:0]  rd_idx_i,
    output nr_pbch_pkg::dmrs_row_t              rd_row_o
);

    localparam int NI = nr_pbch_pkg::NUM_IBAR;
    localparam int DEPTH = nr_pbch_pkg::DMRS_LEN;

    // one pilot table per ibar candidate
    nr_pbch_pkg::qpsk_bits_t tbl_q [NI][DEPTH];

    // every table takes its own Gold bit at the same pilot position
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int i = 0; i < NI; i++) begin
                if (wr_lo_i) begin
                    tbl_q[i][wr_idx_i].b_lo <= wr_bits_i[i];
                end else begin
                    tbl_q[i][wr_idx_i].b_hi <= wr_bits_i[i];
                end
            end
        end
    end

    // the correlator compares all candidates at once, so the read is wide
    always_comb begin
        for (int i = 0; i < NI; i++) begin
            rd_row_o[i] = tbl_q[i][rd_idx_i];
        end
    end

endmodule

//--- pbch_dmrs_detector.sv
`timescale 1ns/1ns

module pbch_dmrs_detector (
    input  logic                                clk_i,
    input  logic                                reset_ni,
    input  nr_pbch_pkg::iq_sample_t             sample_i,
    input  logic                                dmrs_ready_i,
    input  logic [nr_pbch_pkg::NID_W-1:0]       n_id_i,
    output logic [nr_pbch_pkg::DMRS_IDX_W-1:0]  pilot_idx_o,
    output logic                                acc_en_o,
    output logic [nr_pbch_pkg::IQ_W-1:0]        acc_data_o,
    output logic                                clear_o,
    output logic                                decide_o
);

    localparam int SC_CNT_W = 9;
    localparam int SP_W = $clog2(nr_pbch_pkg::PILOT_SPACING);
    localparam int IDX_W = nr_pbch_pkg::DMRS_IDX_W;

    typedef enum logic {S_WAIT, S_COLLECT} state_t;

    state_t              state_q;
    logic [SC_CNT_W-1:0] sc_cnt;
    logic                sc_last;
    logic                sym_start;
    logic                take;
    logic                sym_end;
    logic                is_pilot;

    // a symbol is only accepted once the pilot tables are complete
    assign sym_start = (state_q == S_WAIT) && sample_i.valid && sample_i.start && dmrs_ready_i;
    assign take      = sym_start || ((state_q == S_COLLECT) && sample_i.valid);
    assign sym_end   = (state_q == S_COLLECT) && sample_i.valid && sc_last;

    // sc_cnt is the subcarrier index of the sample in flight
    step_counter #(.WIDTH(SC_CNT_W)) i_sc_cnt (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .clear_i    (sym_end),
        .en_i       (take),
        .last_val_i (SC_CNT_W'(nr_pbch_pkg::FFT_LEN - 1)),
        .count_o    (sc_cnt),
        .at_last_o  (sc_last)
    );

    // pilots sit on every fourth subcarrier, shifted by n_id mod 4
    assign is_pilot    = (sc_cnt[SP_W-1:0] == n_id_i[SP_W-1:0]);
    assign pilot_idx_o = IDX_W'(sc_cnt >> SP_W);
    assign acc_en_o    = take && is_pilot;
    assign acc_data_o  = sample_i.data;
    assign clear_o     = sym_start;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q  <= S_WAIT;
            decide_o <= 1'b0;
        end else begin
            // the last pilot lands in the accumulators on this same edge
            decide_o <= sym_end;
            case (state_q)
                S_WAIT:    state_q <= sym_start ? S_COLLECT : S_WAIT;
                S_COLLECT: state_q <= sym_end ? S_WAIT : S_COLLECT;
                default:   state_q <= S_WAIT;
            endcase
        end
    end

endmodule

//--- ibar_correlator.sv
`timescale 1ns/1ns

module ibar_correlator (
    input  logic                          clk_i,
    input  logic                          reset_ni,
    input  logic                          clear_i,
    input  logic                          acc_en_i,
    input  logic [nr_pbch_pkg::IQ_W-1:0]  acc_data_i,
    input  nr_pbch_pkg::dmrs_row_t        dmrs_row_i,
    input  logic                          decide_i,
    output nr_pbch_pkg::ibar_result_t     result_o
);

    localparam int NI = nr_pbch_pkg::NUM_IBAR;
    localparam int IW = nr_pbch_pkg::IQ_W;
    localparam int CW = nr_pbch_pkg::CORR_W;
    localparam int MW = nr_pbch_pkg::MAG_W;
    localparam int BW = nr_pbch_pkg::IBAR_W;

    typedef logic signed [CW-1:0] corr_t;
    typedef logic [MW-1:0] mag_t;

    // +1 per matching bit and -1 per mismatch
    function automatic corr_t pilot_score(
        input nr_pbch_pkg::qpsk_bits_t exp_bits,
        input nr_pbch_pkg::qpsk_bits_t dec_bits
    );
        logic [1:0] hits;
        hits = {exp_bits.b_hi ~^ dec_bits.b_hi, exp_bits.b_lo ~^ dec_bits.b_lo};
        case (hits)
            2'b11:   return corr_t'(2);
            2'b00:   return corr_t'(-2);
            default: return '0;
        endcase
    endfunction

    // 64 pilots give at most 128, which still fits the magnitude width
    function automatic mag_t magnitude(input corr_t acc);
        corr_t pos;
        pos = acc[CW-1] ? -acc : acc;
        return pos[MW-1:0];
    endfunction

    nr_pbch_pkg::qpsk_bits_t plain_dec;
    nr_pbch_pkg::qpsk_bits_t rot_dec;
    corr_t                   acc_plain_q [NI];
    corr_t                   acc_rot_q [NI];
    mag_t                    best_mag;
    logic [BW-1:0]           best_ibar;
    logic                    res_valid_q;
    mag_t                    res_peak_q;
    logic [BW-1:0]           res_ibar_q;

    // hard QPSK decision from the sign bits of I and Q
    assign plain_dec.b_hi = acc_data_i[IW/2-1];
    assign plain_dec.b_lo = acc_data_i[IW-1];

    // the same sample turned by 90 degrees covers a quarter-turn phase offset
    assign rot_dec.b_hi = ~acc_data_i[IW-1];
    assign rot_dec.b_lo = acc_data_i[IW/2-1];

    // a clear together with a pilot starts the sums at that pilot
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NI; i++) begin
            if (!reset_ni) begin
                acc_plain_q[i] <= '0;
                acc_rot_q[i]   <= '0;
            end else if (clear_i) begin
                acc_plain_q[i] <= acc_en_i ? pilot_score(dmrs_row_i[i], plain_dec) : '0;
                acc_rot_q[i]   <= acc_en_i ? pilot_score(dmrs_row_i[i], rot_dec) : '0;
            end else if (acc_en_i) begin
                acc_plain_q[i] <= acc_plain_q[i] + pilot_score(dmrs_row_i[i], plain_dec);
                acc_rot_q[i]   <= acc_rot_q[i] + pilot_score(dmrs_row_i[i], rot_dec);
            end
        end
    end

    // strict compare keeps the lower ibar and the plain sum on a tie
    always_comb begin
        best_mag  = '0;
        best_ibar = '0;
        for (int i = 0; i < NI; i++) begin
            if (magnitude(acc_plain_q[i]) > best_mag) begin
                best_mag  = magnitude(acc_plain_q[i]);
                best_ibar = BW'(i);
            end
            if (magnitude(acc_rot_q[i]) > best_mag) begin
                best_mag  = magnitude(acc_rot_q[i]);
                best_ibar = BW'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= decide_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (decide_i) begin
            res_ibar_q <= best_ibar;
            res_peak_q <= best_mag;
        end
    end

    assign result_o = '{ibar: res_ibar_q, peak: res_peak_q, valid: res_valid_q};

endmodule

//--- ibar_ssb_top.sv
`timescale 1ns/1ns

module ibar_ssb_top #(
    parameter int SKIP_LEN = nr_pbch_pkg::GOLD_SKIP
) (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  nr_pbch_pkg::cell_cfg_t     cell_cfg_i,
    input  nr_pbch_pkg::iq_sample_t    sample_i,
    output logic                       dmrs_ready_o,
    output nr_pbch_pkg::ibar_result_t  result_o
);

    logic [nr_pbch_pkg::NID_W-1:0]       n_id_q;
    logic                                gen_load;
    logic                                gen_step;
    logic [nr_pbch_pkg::NUM_IBAR-1:0]    gold_bits;
    logic                                wr_en;
    logic [nr_pbch_pkg::DMRS_IDX_W-1:0]  wr_idx;
    logic                                wr_lo;
    logic [nr_pbch_pkg::DMRS_IDX_W-1:0]  pilot_idx;
    nr_pbch_pkg::dmrs_row_t              dmrs_row;
    logic                                acc_en;
    logic [nr_pbch_pkg::IQ_W-1:0]        acc_data;
    logic                                corr_clear;
    logic                                decide;

    // held cell identity drives both the generators and the pilot grid
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            n_id_q <= '0;
        end else if (cell_cfg_i.valid) begin
            n_id_q <= cell_cfg_i.n_id;
        end
    end

    dmrs_seq_ctrl #(.SKIP_LEN(SKIP_LEN)) i_seq_ctrl (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .cell_cfg_i   (cell_cfg_i),
        .gen_load_o   (gen_load),
        .gen_step_o   (gen_step),
        .wr_en_o      (wr_en),
        .wr_idx_o     (wr_idx),
        .wr_lo_o      (wr_lo),
        .dmrs_ready_o (dmrs_ready_o)
    );

    gold_seq_gen i_gold_gen (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .load_i      (gen_load),
        .step_i      (gen_step),
        .n_id_i      (n_id_q),
        .gold_bits_o (gold_bits)
    );

    dmrs_store i_store (
        .clk_i     (clk_i),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_lo_i   (wr_lo),
        .wr_bits_i (gold_bits),
        .rd_idx_i  (pilot_idx),
        .rd_row_o  (dmrs_row)
    );

    pbch_dmrs_detector i_detector (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .sample_i     (sample_i),
        .dmrs_ready_i (dmrs_ready_o),
        .n_id_i       (n_id_q),
        .pilot_idx_o  (pilot_idx),
        .acc_en_o     (acc_en),
        .acc_data_o   (acc_data),
        .clear_o      (corr_clear),
        .decide_o     (decide)
    );

    ibar_correlator i_correlator (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .clear_i    (corr_clear),
        .acc_en_i   (acc_en),
        .acc_data_i (acc_data),
        .dmrs_row_i (dmrs_row),
        .decide_i   (decide),
        .result_o   (result_o)
    );

endmodule

//--- tb_ibar_ssb.sv
`timescale 1ns/1ns

module tb_ibar_ssb;

    localparam int PILOTS = nr_pbch_pkg::FFT_LEN / nr_pbch_pkg::PILOT_SPACING;
    localparam int SEQ_BITS = 2 * PILOTS;
    localparam int X_LEN = nr_pbch_pkg::GOLD_SKIP + SEQ_BITS;
    localparam int READY_CYCLES = 1 + nr_pbch_pkg::GOLD_SKIP + 2 + 2 * nr_pbch_pkg::DMRS_LEN;
    // twelve times one sequence build plus one symbol with margin
    localparam int TIMEOUT_CYCLES = 12 * (READY_CYCLES + 300);

    logic                      clk_i;
    logic                      reset_ni;
    nr_pbch_pkg::cell_cfg_t    cell_cfg;
    nr_pbch_pkg::iq_sample_t   sample;
    logic                      dmrs_ready_o;
    nr_pbch_pkg::ibar_result_t result_o;

    int          seed;
    int          cycle_count;
    int          result_count;
    logic [1:0]  ref_pilot [nr_pbch_pkg::NUM_IBAR][PILOTS];
    logic        x1 [X_LEN];
    logic        x2 [X_LEN];
    logic [31:0] sym_data [nr_pbch_pkg::FFT_LEN];

    ibar_ssb_top i_dut (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .cell_cfg_i   (cell_cfg),
        .sample_i     (sample),
        .dmrs_ready_o (dmrs_ready_o),
        .result_o     (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "simulation timed out");
    end

    // every result pulse is counted, so stray results show up
    initial begin
        result_count = 0;
        forever begin
            @(negedge clk_i);
            if (result_o.valid === 1'b1) result_count++;
        end
    end

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // x1 starts at 1, x2 at c_init, and c(n) skips the first 1600 bits
    task automatic build_reference(input int n_id);
        int c_init;
        int base;
        for (int ib = 0; ib < nr_pbch_pkg::NUM_IBAR; ib++) begin
            c_init = 2048 * (ib + 1) * (n_id / 4 + 1) + 64 * (ib + 1) + n_id % 4;
            for (int n = 0; n < 31; n++) begin
                x1[n] = (n == 0);
                x2[n] = c_init[n];
            end
            for (int n = 0; n + 31 < X_LEN; n++) begin
                x1[n+31] = x1[n+3] ^ x1[n];
                x2[n+31] = x2[n+3] ^ x2[n+2] ^ x2[n+1] ^ x2[n];
            end
            for (int m = 0; m < PILOTS; m++) begin
                base = nr_pbch_pkg::GOLD_SKIP + 2 * m;
                ref_pilot[ib][m] = {x1[base] ^ x2[base], x1[base+1] ^ x2[base+1]};
            end
        end
    endtask

    function automatic logic [31:0] iq_word(input logic i_neg, input logic q_neg);
        logic [15:0] i_part;
        logic [15:0] q_part;
        i_part = i_neg ? 16'(-3000) : 16'(3000);
        q_part = q_neg ? 16'(-2500) : 16'(2500);
        return {q_part, i_part};
    endfunction

    // pilots follow one ibar, the other subcarriers carry random data
    task automatic build_symbol(input int n_id, input int ibar, input bit rotated);
        logic [1:0] p;
        for (int k = 0; k < nr_pbch_pkg::FFT_LEN; k++) begin
            if ((k + 4 - n_id % 4) % 4 == 0) begin
                p = ref_pilot[ibar][k/4];
                sym_data[k] = rotated ? iq_word(p[0], !p[1]) : iq_word(p[1], p[0]);
            end else begin
                sym_data[k] = $random(seed);
            end
        end
    endtask

    // scores all sixteen hypotheses, ties go to the lower ibar and to plain
    task automatic expected_result(input int n_id, output int e_ibar, output int e_peak);
        int plain_acc [nr_pbch_pkg::NUM_IBAR];
        int rot_acc [nr_pbch_pkg::NUM_IBAR];
        logic [1:0] pd;
        logic [1:0] rd;
        logic [1:0] p;
        int m;
        for (int j = 0; j < nr_pbch_pkg::NUM_IBAR; j++) begin
            plain_acc[j] = 0;
            rot_acc[j] = 0;
        end
        for (int k = 0; k < nr_pbch_pkg::FFT_LEN; k++) begin
            if ((k + 4 - n_id % 4) % 4 == 0) begin
                m = k / 4;
                pd = {sym_data[k][15], sym_data[k][31]};
                rd = {!sym_data[k][31], sym_data[k][15]};
                for (int j = 0; j < nr_pbch_pkg::NUM_IBAR; j++) begin
                    p = ref_pilot[j][m];
                    plain_acc[j] += (pd[1] == p[1] ? 1 : -1) + (pd[0] == p[0] ? 1 : -1);
                    rot_acc[j] += (rd[1] == p[1] ? 1 : -1) + (rd[0] == p[0] ? 1 : -1);
                end
            end
        end
        e_ibar = 0;
        e_peak = -1;
        for (int j = 0; j < nr_pbch_pkg::NUM_IBAR; j++) begin
            if ((plain_acc[j] < 0 ? -plain_acc[j] : plain_acc[j]) > e_peak) begin
                e_peak = plain_acc[j] < 0 ? -plain_acc[j] : plain_acc[j];
                e_ibar = j;
            end
            if ((rot_acc[j] < 0 ? -rot_acc[j] : rot_acc[j]) > e_peak) begin
                e_peak = rot_acc[j] < 0 ? -rot_acc[j] : rot_acc[j];
                e_ibar = j;
            end
        end
    endtask

    task automatic write_cell_id(input int n_id);
        @(posedge clk_i);
        cell_cfg <= '{n_id: 10'(n_id), valid: 1'b1};
        @(posedge clk_i);
        cell_cfg.valid <= 1'b0;
    endtask

    // counts edges from the one that sampled the write until ready is seen
    task automatic wait_dmrs_ready(output int cycles);
        cycles = 0;
        @(negedge clk_i);
        while (dmrs_ready_o !== 1'b1) begin
            @(negedge clk_i);
            cycles++;
        end
    endtask

    task automatic send_symbol(input bit gaps);
        for (int k = 0; k < nr_pbch_pkg::FFT_LEN; k++) begin
            @(posedge clk_i);
            sample <= '{data: sym_data[k], start: (k == 0), valid: 1'b1};
            if (gaps && k != nr_pbch_pkg::FFT_LEN - 1) begin
                repeat (k % 3) begin
                    @(posedge clk_i);
                    sample <= '{data: $random(seed), start: 1'b0, valid: 1'b0};
                end
            end
        end
        @(posedge clk_i);
        sample <= '{data: '0, start: 1'b0, valid: 1'b0};
    endtask

    // the result is a single pulse two edges after the last sample
    task automatic run_symbol(input int n_id, input int ibar, input bit rotated, input bit gaps);
        int e_ibar;
        int e_peak;
        build_symbol(n_id, ibar, rotated);
        expected_result(n_id, e_ibar, e_peak);
        check_eq(32'(e_ibar), 32'(ibar), "model ibar for the built symbol");
        check_eq(32'(e_peak), 32'd128, "model peak for the built symbol");
        send_symbol(gaps);
        @(negedge clk_i);
        check_eq(32'(result_o.valid), 32'd0, "result valid one edge after the last sample");
        @(negedge clk_i);
        check_eq(32'(result_o.valid), 32'd1, "result valid two edges after the last sample");
        check_eq(32'(result_o.ibar), 32'(e_ibar), "result ibar");
        check_eq(32'(result_o.peak), 32'(e_peak), "result peak");
        @(negedge clk_i);
        check_eq(32'(result_o.valid), 32'd0, "result valid after the pulse");
    endtask

    task automatic test_reset_and_ready();
        int cycles;
        check_eq(32'(dmrs_ready_o), 32'd0, "dmrs_ready_o after reset");
        check_eq(32'(result_o.valid), 32'd0, "result valid after reset");
        build_reference(0);
        write_cell_id(0);
        wait_dmrs_ready(cycles);
        check_eq(32'(cycles), 32'(READY_CYCLES), "cycles until dmrs_ready_o for N_id 0");
    endtask

    task automatic test_plain_ibar5();
        run_symbol(0, 5, 1'b0, 1'b0);
    endtask

    task automatic test_rotated_ibar2();
        run_symbol(0, 2, 1'b1, 1'b0);
    endtask

    task automatic test_all_ibar_gaps();
        int cycles;
        build_reference(1006);
        write_cell_id(1006);
        wait_dmrs_ready(cycles);
        check_eq(32'(cycles), 32'(READY_CYCLES), "cycles until dmrs_ready_o for N_id 1006");
        for (int ib = 0; ib < nr_pbch_pkg::NUM_IBAR; ib++) begin
            run_symbol(1006, ib, 1'b0, 1'b1);
        end
    endtask

    // a new write drops ready, so the following start mark is ignored
    task automatic test_start_while_busy();
        int count_before;
        write_cell_id(1006);
        count_before = result_count;
        build_symbol(1006, 3, 1'b0);
        send_symbol(1'b0);
        repeat (8) @(posedge clk_i);
        check_eq(32'(result_count), 32'(count_before), "results after a start while not ready");
    endtask

    initial begin
        seed = 41;
        reset_ni = 1'b0;
        cell_cfg = '0;
        sample = '0;
        repeat (2) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(negedge clk_i);
        test_reset_and_ready();
        test_plain_ibar5();
        test_rotated_ibar2();
        test_all_ibar_gaps();
        test_start_while_busy();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- flist.f
nr_pbch_pkg.sv
step_counter.sv
gold_seq_gen.sv
dmrs_seq_ctrl.sv
dmrs_store.sv
pbch_dmrs_detector.sv
ibar_correlator.sv
ibar_ssb_top.sv
tb_ibar_ssb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_ibar_ssb -f flist.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
